// File: include/rv_defines.svh
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// datapath and address width
`define XLEN 32

// first fetch address after reset
`define RESET_PC 32'h8000_0000

// pc increment for sequential flow
`define PC_STEP 32'd4

// architectural register file
`define NUM_REGS 32
`define REG_AW 5

// one mask bit per byte lane
`define MASK_W 4

// cycles kept under watch once the core has halted
`define HALT_CYCLES 8

`endif

// File: src/rv_pkg.sv
`include "rv_defines.svh"

package rv_pkg;

  // major opcodes handled by the core
  typedef enum logic [6:0] {
    op_imm = 7'b001_0011, // addi only
    lui    = 7'b011_0111,
    auipc  = 7'b001_0111,
    jal    = 7'b110_1111,
    jalr   = 7'b110_0111,
    load   = 7'b000_0011,
    store  = 7'b010_0011,
    system = 7'b111_0011  // ebreak
  } opcode_e;

  // funct3 of loads and stores
  typedef enum logic [2:0] {
    byte_s = 3'b000, // lb / sb
    half_s = 3'b001, // lh / sh
    word_s = 3'b010, // lw / sw
    byte_u = 3'b100, // lbu
    half_u = 3'b101  // lhu
  } mem_size_e;

  // everything the datapath needs from one instruction word
  typedef struct packed {
    opcode_e              opcode;
    mem_size_e            funct3;
    logic [`REG_AW-1:0]   rd;
    logic [`REG_AW-1:0]   rs1;
    logic [`REG_AW-1:0]   rs2;
    logic [`XLEN-1:0]     imm;    // already picked for the opcode
    logic                 legal;
  } decoded_t;

  // data memory request, valid in the cycle of the instruction
  typedef struct packed {
    logic                 re;
    logic                 we;
    logic [`XLEN-1:0]     addr;
    logic [`XLEN-1:0]     wdata;  // lane aligned
    logic [`MASK_W-1:0]   wmask;
  } dmem_req_t;

endpackage

// File: src/inst_decoder.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module inst_decoder (
  input  logic [`XLEN-1:0] inst,
  output rv_pkg::decoded_t dec
);

  rv_pkg::opcode_e   opcode;
  logic [2:0]        funct3;
  logic [`XLEN-1:0]  imm_i;
  logic [`XLEN-1:0]  imm_s;
  logic [`XLEN-1:0]  imm_u;
  logic [`XLEN-1:0]  imm_j;
  logic              is_ebreak_word;

  assign opcode = rv_pkg::opcode_e'(inst[6:0]);
  assign funct3 = inst[14:12];

  // sign-extended immediates of each format
  assign imm_i = {{(`XLEN-12){inst[31]}}, inst[31:20]};
  assign imm_s = {{(`XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_u = {inst[31:12], 12'h000}; // upper 20 bits, low part zero
  assign imm_j = {{(`XLEN-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  // ebreak has imm = 1 and every other field zero
  assign is_ebreak_word = (inst[31:20] == 12'h001) && (inst[19:7] == 13'h0000);

  always_comb begin
    dec.opcode = opcode;
    dec.funct3 = rv_pkg::mem_size_e'(funct3);
    dec.rd     = inst[11:7];
    dec.rs1    = inst[19:15];
    dec.rs2    = inst[24:20];
    dec.imm    = '0;
    dec.legal  = 1'b0;

    case (opcode)
      rv_pkg::op_imm: begin
        dec.imm   = imm_i;
        dec.legal = (funct3 == 3'b000); // addi only
      end
      rv_pkg::lui, rv_pkg::auipc: begin
        dec.imm   = imm_u;
        dec.legal = 1'b1;
      end
      rv_pkg::jal: begin
        dec.imm   = imm_j;
        dec.legal = 1'b1;
      end
      rv_pkg::jalr: begin
        dec.imm   = imm_i;
        dec.legal = (funct3 == 3'b000);
      end
      rv_pkg::load: begin
        dec.imm   = imm_i;
        dec.legal = funct3 inside {rv_pkg::byte_s, rv_pkg::half_s, rv_pkg::word_s,
                                   rv_pkg::byte_u, rv_pkg::half_u};
      end
      rv_pkg::store: begin
        dec.imm   = imm_s;
        dec.legal = funct3 inside {rv_pkg::byte_s, rv_pkg::half_s, rv_pkg::word_s};
      end
      rv_pkg::system: begin
        dec.imm   = imm_i;
        dec.legal = is_ebreak_word; // ecall and csr ops not handled
      end
      default: begin
        // unknown opcode stays illegal
        dec.legal = 1'b0;
      end
    endcase
  end

endmodule

// File: src/reg_file.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module reg_file (
  input  logic               clk,
  input  logic [`REG_AW-1:0] rs1_addr,
  input  logic [`REG_AW-1:0] rs2_addr,
  input  logic [`REG_AW-1:0] rd_addr,
  input  logic               rd_we,
  input  logic [`XLEN-1:0]   rd_data,
  output logic [`XLEN-1:0]   rs1_data,
  output logic [`XLEN-1:0]   rs2_data
);

  logic [`XLEN-1:0] regs [`NUM_REGS];

  // x0 is never written
  always_ff @(posedge clk) begin
    if (rd_we && (rd_addr != '0)) begin
      regs[rd_addr] <= rd_data;
    end
  end

  // combinational reads, x0 forced to zero
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// File: src/execute_unit.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module execute_unit (
  input  logic              clk,
  input  logic              rst_n,
  input  rv_pkg::decoded_t  dec,
  input  logic [`XLEN-1:0]  rs1_data,
  input  logic [`XLEN-1:0]  load_data,
  output logic [`XLEN-1:0]  pc,
  output logic              halted,
  output logic [`XLEN-1:0]  addr_sum,
  output logic              rd_we,
  output logic [`XLEN-1:0]  rd_data
);

  logic [`XLEN-1:0] op_a;
  logic [`XLEN-1:0] pc_plus4;
  logic [`XLEN-1:0] next_pc;
  logic             writes_rd;
  logic             is_ebreak;

  assign pc_plus4  = pc + `PC_STEP;
  assign is_ebreak = dec.legal && (dec.opcode == rv_pkg::system);

  // first adder operand
  always_comb begin
    case (dec.opcode)
      rv_pkg::auipc, rv_pkg::jal: op_a = pc;
      rv_pkg::lui:                op_a = '0; // imm passes straight through
      default:                    op_a = rs1_data;
    endcase
  end

  // one adder for addi, lui, auipc, jump targets and memory addresses
  assign addr_sum = op_a + dec.imm;

  always_comb begin
    next_pc = pc_plus4;
    if (dec.legal) begin
      case (dec.opcode)
        rv_pkg::jal:    next_pc = addr_sum;
        rv_pkg::jalr:   next_pc = {addr_sum[`XLEN-1:1], 1'b0};
        rv_pkg::system: next_pc = pc; // pc parks on the ebreak
        default:        next_pc = pc_plus4;
      endcase
    end
  end

  always_comb begin
    case (dec.opcode)
      rv_pkg::op_imm, rv_pkg::lui, rv_pkg::auipc,
      rv_pkg::jal, rv_pkg::jalr, rv_pkg::load: writes_rd = 1'b1;
      default:                                 writes_rd = 1'b0;
    endcase
  end

  assign rd_we = writes_rd && dec.legal && !halted && rst_n;

  // write-back source
  always_comb begin
    case (dec.opcode)
      rv_pkg::jal, rv_pkg::jalr: rd_data = pc_plus4; // link address
      rv_pkg::load:              rd_data = load_data;
      default:                   rd_data = addr_sum;
    endcase
  end

  // halted is sticky until reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc     <= `RESET_PC;
      halted <= 1'b0;
    end else if (!halted) begin
      pc     <= next_pc;
      halted <= is_ebreak;
    end
  end

endmodule

// File: src/lsu.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module lsu (
  input  rv_pkg::decoded_t   dec,
  input  logic [`XLEN-1:0]   addr_sum,
  input  logic [`XLEN-1:0]   rs2_data,
  input  logic [`XLEN-1:0]   mem_rdata,
  input  logic               halted,
  input  logic               rst_n,
  output rv_pkg::dmem_req_t  dmem_req,
  output logic [`XLEN-1:0]   load_data
);

  logic               active;
  logic               do_load;
  logic               do_store;
  logic [1:0]         offset;
  logic [4:0]         byte_shift;
  logic [4:0]         half_shift;
  logic [`XLEN-1:0]   lane_data;
  logic [`MASK_W-1:0] mask;
  logic [7:0]         rd_byte;
  logic [15:0]        rd_half;

  assign active   = rst_n && !halted && dec.legal;
  assign do_load  = active && (dec.opcode == rv_pkg::load);
  assign do_store = active && (dec.opcode == rv_pkg::store);

  assign offset     = addr_sum[1:0];
  assign byte_shift = {offset, 3'b000};     // bit position of the byte lane
  assign half_shift = {offset[1], 4'b0000}; // low or high half

  // store data onto its lane, mask per size
  always_comb begin
    case (dec.funct3)
      rv_pkg::byte_s: begin
        lane_data = rs2_data << byte_shift;
        mask      = 4'b0001 << offset;
      end
      rv_pkg::half_s: begin
        lane_data = rs2_data << half_shift;
        mask      = offset[1] ? 4'b1100 : 4'b0011;
      end
      rv_pkg::word_s: begin
        lane_data = rs2_data;
        mask      = 4'b1111;
      end
      default: begin
        lane_data = rs2_data;
        mask      = '0;
      end
    endcase
  end

  always_comb begin
    dmem_req.re    = do_load;
    dmem_req.we    = do_store;
    dmem_req.addr  = addr_sum;
    dmem_req.wdata = lane_data;
    dmem_req.wmask = do_store ? mask : '0; // no lanes enabled without a write
  end

  // pick the addressed byte and half of the read word
  assign rd_byte = 8'(mem_rdata >> byte_shift);
  assign rd_half = 16'(mem_rdata >> half_shift);

  always_comb begin
    case (dec.funct3)
      rv_pkg::byte_s: load_data = {{(`XLEN-8){rd_byte[7]}}, rd_byte};
      rv_pkg::half_s: load_data = {{(`XLEN-16){rd_half[15]}}, rd_half};
      rv_pkg::byte_u: load_data = {{(`XLEN-8){1'b0}}, rd_byte};
      rv_pkg::half_u: load_data = {{(`XLEN-16){1'b0}}, rd_half};
      default:        load_data = mem_rdata; // lw
    endcase
  end

endmodule

// File: src/rv_core_top.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_core_top (
  input  logic               clk,
  input  logic               rst_n,
  input  logic [`XLEN-1:0]   inst,
  input  logic [`XLEN-1:0]   mem_rdata,
  output logic [`XLEN-1:0]   pc,
  output rv_pkg::dmem_req_t  dmem_req,
  output logic               halted
);

  rv_pkg::decoded_t  dec;
  logic [`XLEN-1:0]  rs1_data;
  logic [`XLEN-1:0]  rs2_data;
  logic              rd_we;
  logic [`XLEN-1:0]  rd_data;
  logic [`XLEN-1:0]  addr_sum;
  logic [`XLEN-1:0]  load_data;

  inst_decoder i_decoder (
    .inst (inst),
    .dec  (dec)
  );

  reg_file i_reg_file (
    .clk      (clk),
    .rs1_addr (dec.rs1),
    .rs2_addr (dec.rs2),
    .rd_addr  (dec.rd),
    .rd_we    (rd_we),
    .rd_data  (rd_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  execute_unit i_execute (
    .clk       (clk),
    .rst_n     (rst_n),
    .dec       (dec),
    .rs1_data  (rs1_data),
    .load_data (load_data),
    .pc        (pc),
    .halted    (halted),
    .addr_sum  (addr_sum),
    .rd_we     (rd_we),
    .rd_data   (rd_data)
  );

  // memory side, combinational toward the port
  lsu i_lsu (
    .dec       (dec),
    .addr_sum  (addr_sum),
    .rs2_data  (rs2_data),
    .mem_rdata (mem_rdata),
    .halted    (halted),
    .rst_n     (rst_n),
    .dmem_req  (dmem_req),
    .load_data (load_data)
  );

endmodule

// File: testbench/rv_core_properties.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_core_properties (
  input logic              clk,
  input logic              rst_n,
  input logic [`XLEN-1:0]  pc,
  input rv_pkg::dmem_req_t dmem_req,
  input logic              halted
);

  int fails = 0; // failed assertions so far

  // pc back at the reset vector one edge into reset
  a_reset_pc: assert property (@(posedge clk) !rst_n |=> pc == `RESET_PC)
    else begin
      fails++;
      $error("pc not at reset vector after reset edge");
    end

  a_reset_strobes: assert property (@(posedge clk) !rst_n |-> !dmem_req.re && !dmem_req.we)
    else begin
      fails++;
      $error("memory strobe active during reset");
    end

  // a write always enables the lane its address points at
  a_mask_lane: assert property (@(posedge clk) disable iff (!rst_n)
    dmem_req.we |-> dmem_req.wmask[dmem_req.addr[1:0]])
    else begin
      fails++;
      $error("write mask misses the addressed byte lane");
    end

  a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00)
    else begin
      fails++;
      $error("pc not word aligned");
    end

  a_halt_sticky: assert property (@(posedge clk) disable iff (!rst_n)
    halted |=> halted && $stable(pc))
    else begin
      fails++;
      $error("core left halt or pc moved while halted");
    end

  a_halt_no_write: assert property (@(posedge clk) disable iff (!rst_n)
    halted |-> !dmem_req.we)
    else begin
      fails++;
      $error("memory write while halted");
    end

endmodule

bind rv_core_top rv_core_properties i_props (
  .clk      (clk),
  .rst_n    (rst_n),
  .pc       (pc),
  .dmem_req (dmem_req),
  .halted   (halted)
);

// File: testbench/tb_rv_core.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module tb_rv_core;

  localparam int PROG_LEN     = 64;
  localparam int RESET_CYCLES = 4;
  localparam int NUM_TESTS    = 6;
  localparam logic [31:0] EBREAK    = 32'h0010_0073;
  localparam logic [31:0] DATA_BASE = 32'h100;

  logic              clk;
  logic              rst_n;
  logic [`XLEN-1:0]  inst;
  logic [`XLEN-1:0]  mem_rdata;
  logic [`XLEN-1:0]  pc;
  rv_pkg::dmem_req_t dmem_req;
  logic              halted;

  // program image and the expected effect of each slot
  logic [31:0] prog [PROG_LEN];
  logic [31:0] exp_next [PROG_LEN];
  logic        chk_store [PROG_LEN];
  logic        chk_load [PROG_LEN];
  logic [31:0] exp_addr [PROG_LEN];
  logic [31:0] exp_wdata [PROG_LEN];
  logic [3:0]  exp_wmask [PROG_LEN];
  int          tid [PROG_LEN];

  logic [31:0] mem [64];
  logic [31:0] mem_init [64];
  logic [31:0] lfsr;
  logic [31:0] mpc; // model pc
  logic [31:0] store_probe; // sw offered in reset and once halted
  logic [31:0] load_probe;
  string       names [NUM_TESTS];
  int          errs [NUM_TESTS];
  int          checks [NUM_TESTS];
  int          n_inst;
  int          cur_test;
  int          cycles;
  int          limit;
  int          halt_cycles;
  bit          m_halted; // model halt flag
  bit          done;
  bit          timed_out;

  rv_core_top i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .inst      (inst),
    .mem_rdata (mem_rdata),
    .pc        (pc),
    .dmem_req  (dmem_req),
    .halted    (halted)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function logic [31:0] rand_bits(input int nbits);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0); // galois step
      val  = {val[30:0], lfsr[0]};
    end
    return val;
  endfunction

  function int slot(input logic [31:0] addr);
    return int'(((addr - `RESET_PC) >> 2) & 32'h3f);
  endfunction

  function logic [31:0] pc_of(input int idx);
    return `RESET_PC + 32'(idx * 4);
  endfunction

  function logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                              input logic [2:0] f3, input logic [4:0] rd,
                              input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function logic [31:0] enc_sw(input logic [11:0] imm, input logic [4:0] rs2,
                               input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b010_0011};
  endfunction

  function logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b110_1111};
  endfunction

  task automatic put(input logic [31:0] word);
    prog[n_inst]      = word;
    exp_next[n_inst]  = pc_of(n_inst + 1);
    chk_store[n_inst] = 1'b0;
    chk_load[n_inst]  = 1'b0;
    tid[n_inst]       = cur_test;
    n_inst++;
  endtask

  // store relative to x1, the data base
  task automatic put_store(input logic [2:0] f3, input logic [11:0] off,
                           input logic [4:0] rs2, input logic [31:0] wdata,
                           input logic [3:0] wmask);
    put(enc_sw(off, rs2, 5'd1, f3));
    chk_store[n_inst-1] = 1'b1;
    exp_addr[n_inst-1]  = DATA_BASE + {{20{off[11]}}, off};
    exp_wdata[n_inst-1] = wdata;
    exp_wmask[n_inst-1] = wmask;
  endtask

  // load of one size at one offset, then the result goes back out through sw
  task automatic load_case(input logic [2:0] f3, input int off);
    logic [31:0] w;
    logic [31:0] data;
    logic [7:0]  b;
    logic [15:0] h;
    logic [31:0] expv;
    logic [11:0] lofs;
    w    = rand_bits(4);
    data = mem_init[w];
    b    = 8'(data >> (8 * off));
    h    = 16'(data >> (8 * off));
    case (f3)
      3'b000:  expv = {{24{b[7]}}, b};
      3'b001:  expv = {{16{h[15]}}, h};
      3'b100:  expv = {24'h0, b};
      3'b101:  expv = {16'h0, h};
      default: expv = data;
    endcase
    lofs = 12'(w * 4 + off);
    put(enc_i(lofs, 5'd1, f3, 5'd9, 7'b000_0011));
    chk_load[n_inst-1] = 1'b1;
    exp_addr[n_inst-1] = DATA_BASE + 32'(lofs);
    put_store(3'b010, 12'd200, 5'd9, expv, 4'b1111);
  endtask

  task automatic build_program();
    logic [11:0] imm;
    logic [19:0] u;
    logic [31:0] p;
    n_inst      = 0;
    store_probe = enc_sw(12'd128, 5'd2, 5'd1, 3'b010);
    load_probe  = enc_i(12'd0, 5'd1, 3'b010, 5'd9, 7'b000_0011);
    cur_test    = 1;
    put(enc_i(DATA_BASE[11:0], 5'd0, 3'b000, 5'd1, 7'b001_0011)); // x1 = data base
    imm = 12'(rand_bits(12));
    put(enc_i(imm, 5'd0, 3'b000, 5'd2, 7'b001_0011));
    put_store(3'b010, 12'd128, 5'd2, {{20{imm[11]}}, imm}, 4'b1111);
    u = 20'(rand_bits(20));
    put({u, 5'd3, 7'b011_0111});
    put_store(3'b010, 12'd132, 5'd3, {u, 12'h0}, 4'b1111);
    u = 20'(rand_bits(20));
    p = pc_of(n_inst);
    put({u, 5'd4, 7'b001_0111});
    put_store(3'b010, 12'd136, 5'd4, p + {u, 12'h0}, 4'b1111);

    cur_test = 2;
    p = pc_of(n_inst);
    put(enc_j(21'd8, 5'd5));
    exp_next[n_inst-1] = p + 32'd8;
    put(enc_i(12'h7ff, 5'd0, 3'b000, 5'd0, 7'b001_0011)); // skipped
    put_store(3'b010, 12'd140, 5'd5, p + 32'd4, 4'b1111);
    p = pc_of(n_inst);
    put({20'h0, 5'd6, 7'b001_0111}); // x6 = own pc
    put(enc_i(12'd13, 5'd6, 3'b000, 5'd7, 7'b110_0111)); // odd target, bit 0 drops
    exp_next[n_inst-1] = p + 32'd12;
    put(enc_i(12'h7ff, 5'd0, 3'b000, 5'd0, 7'b001_0011));
    put_store(3'b010, 12'd144, 5'd7, p + 32'd8, 4'b1111);

    cur_test = 3;
    imm = 12'(rand_bits(12));
    put(enc_i(imm, 5'd0, 3'b000, 5'd8, 7'b001_0011));
    p = {{20{imm[11]}}, imm};
    for (int k = 0; k < 4; k++) begin
      put_store(3'b000, 12'(148 + k), 5'd8, p << (8 * k), 4'b0001 << k);
    end
    put_store(3'b001, 12'd152, 5'd8, p, 4'b0011);
    put_store(3'b001, 12'd154, 5'd8, p << 16, 4'b1100);

    cur_test = 4;
    for (int k = 0; k < 4; k++) begin
      load_case(3'b000, k);
      load_case(3'b100, k);
    end
    for (int k = 0; k < 4; k += 2) begin
      load_case(3'b001, k);
      load_case(3'b101, k);
    end
    load_case(3'b010, 0);

    cur_test = 5;
    put(EBREAK);
    exp_next[n_inst-1] = pc_of(n_inst - 1); // parks here
  endtask

  task automatic check(input int t, input string what, input logic [31:0] expv,
                       input logic [31:0] actv);
    checks[t]++;
    assert (expv === actv) else begin
      $display("FAIL %s %s: expected %h, actual %h", names[t], what, expv, actv);
      errs[t]++;
    end
  endtask

  task automatic report_test(input int t);
    $display("test %-8s %0d checks, %0d errors", names[t], checks[t], errs[t]);
  endtask

  // combinational read, byte-lane writes at the edge
  assign mem_rdata = mem[dmem_req.addr[7:2]];

  always @(posedge clk) begin
    if (dmem_req.we) begin
      for (int b = 0; b < 4; b++) begin
        if (dmem_req.wmask[b]) mem[dmem_req.addr[7:2]][8*b +: 8] <= dmem_req.wdata[8*b +: 8];
      end
    end
  end

  // reference pc and instruction feed
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (rst_n) begin
      if (prog[slot(mpc)] == EBREAK) m_halted = 1'b1;
      mpc = exp_next[slot(mpc)];
      // once halted a store is offered, it must neither write nor move the pc
      inst <= m_halted ? store_probe : prog[slot(mpc)];
    end
    if (cycles > limit) timed_out = 1'b1;
  end

  always @(negedge clk) begin
    int s;
    s = slot(mpc);
    if (!rst_n) begin
      check(0, "pc", `RESET_PC, pc);
      check(0, "re", 32'd0, 32'(dmem_req.re));
      check(0, "we", 32'd0, 32'(dmem_req.we));
      check(0, "halted", 32'd0, 32'(halted));
    end else if (!done) begin
      if (tid[s] != cur_test) begin
        report_test(cur_test);
        cur_test = tid[s];
      end
      check(tid[s], "pc", mpc, pc);
      check(tid[s], "re", 32'(chk_load[s]), 32'(dmem_req.re));
      check(tid[s], "we", 32'(chk_store[s]), 32'(dmem_req.we));
      if (chk_load[s] || chk_store[s]) check(tid[s], "addr", exp_addr[s], dmem_req.addr);
      if (chk_store[s]) begin
        check(tid[s], "wdata", exp_wdata[s], dmem_req.wdata);
        check(tid[s], "wmask", 32'(exp_wmask[s]), 32'(dmem_req.wmask));
      end
      if (m_halted) begin
        check(5, "halted", 32'd1, 32'(halted));
        halt_cycles++;
        if (halt_cycles >= `HALT_CYCLES) begin
          report_test(5);
          done = 1'b1;
        end
      end
    end
  end

  initial begin
    int total_errs;
    int total_checks;
    names = '{"reset", "arith", "jump", "substore", "load", "halt"};
    foreach (errs[i]) begin
      errs[i]   = 0;
      checks[i] = 0;
    end
    lfsr = 32'h619a;
    for (int i = 0; i < 64; i++) begin
      mem_init[i] = rand_bits(32);
      mem[i]      = mem_init[i];
    end
    build_program();
    limit       = n_inst * 2 + 50 + RESET_CYCLES;
    cur_test    = 0;
    cycles      = 0;
    halt_cycles = 0;
    m_halted    = 1'b0;
    done        = 1'b0;
    timed_out   = 1'b0;
    mpc         = `RESET_PC;
    inst        = store_probe; // strobes must stay low in reset
    rst_n       = 1'b0;
    repeat (RESET_CYCLES / 2) @(posedge clk);
    inst <= load_probe;
    repeat (RESET_CYCLES / 2) @(posedge clk);
    inst  <= prog[0];
    rst_n <= 1'b1;
    wait (done || timed_out);
    total_errs   = i_dut.i_props.fails; // bound assertion failures
    total_checks = 0;
    foreach (errs[i]) begin
      total_errs   += errs[i];
      total_checks += checks[i];
    end
    if (timed_out) $display("run stopped after %0d cycles without reaching the halt", cycles);
    $display("tests: %0d, checks: %0d, errors: %0d", NUM_TESTS, total_checks, total_errs);
    if (!timed_out && total_errs == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+include
src/rv_pkg.sv
src/inst_decoder.sv
src/reg_file.sv
src/execute_unit.sv
src/lsu.sv
src/rv_core_top.sv
testbench/rv_core_properties.sv
testbench/tb_rv_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "sim failed" $(LOG); then \
		echo "failure reported, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "sim passed" $(LOG); then \
		echo "run ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
